// ==== design/qspi_csr_pkg.sv ====
// shared types and address map; addresses are 5 bits, so the map ends at 0x1F
package qspi_csr_pkg;

    typedef logic [4:0] addr_t;

    // decoded command byte, bit 7 write flag, bits 4..0 address
    typedef struct packed {
        logic  is_write;
        addr_t addr;
    } qspi_cmd_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        addr_t      paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        PH_CMD,  // command byte
        PH_TURN, // dummy byte of a read frame
        PH_DATA
    } frame_phase_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

    localparam addr_t      REGBANK_LAST    = 5'h0f;
    localparam addr_t      MBOX_DATA_ADDR  = 5'h10;
    localparam addr_t      MBOX_COUNT_ADDR = 5'h11;
    localparam logic [7:0] UNMAPPED_READ   = 8'hee;

endpackage

// ==== design/qspi_serial_port.sv ====
// sck domain only; sck must be at most clk/8 and idle between frames with nss high
`timescale 1ns/1ps

module qspi_serial_port (
    input  logic                    sck,
    input  logic                    nss,
    input  logic                    spi_reset_n,
    input  logic [3:0]              sdi,
    input  logic [7:0]              rd_data,
    output logic [3:0]              sdo,
    output logic                    sdo_en,
    output qspi_csr_pkg::qspi_cmd_t cmd,
    output logic [7:0]              wr_byte,
    output logic                    wr_toggle,
    output logic                    rd_toggle
);

    logic                       frame_rst_n;
    logic                       nib_cnt;   // high while the low nibble is on sdi
    logic [3:0]                 hi_nib;
    logic [7:0]                 rx_byte;
    logic                       byte_end;
    logic                       wr_evt;
    logic                       rd_evt;
    logic                       tx_load;
    logic [7:0]                 tx_reg;
    qspi_csr_pkg::frame_phase_e phase;

    assign frame_rst_n = spi_reset_n & ~nss; // nss high holds the frame logic in reset
    assign rx_byte     = {hi_nib, sdi};
    assign byte_end    = nib_cnt;

    // write event on the last edge of each data byte of a write frame
    assign wr_evt = byte_end && (phase == qspi_csr_pkg::PH_DATA) && cmd.is_write;

    // read event one sck after the previous byte ended, so the result is
    // ready a byte ahead of the controller; turnaround plus N data gives N+1
    assign rd_evt = !byte_end && (phase != qspi_csr_pkg::PH_CMD) && !cmd.is_write;

    // falling edge that opens a data byte of a read frame
    assign tx_load = !nib_cnt && (phase == qspi_csr_pkg::PH_DATA) && !cmd.is_write;

    assign sdo = tx_reg[7:4]; // high nibble first

    always_ff @(posedge sck or negedge frame_rst_n) begin
        if (!frame_rst_n) begin
            nib_cnt <= 1'b0;
            phase   <= qspi_csr_pkg::PH_CMD;
        end else begin
            nib_cnt <= ~nib_cnt;
            if (byte_end) begin
                case (phase)
                    qspi_csr_pkg::PH_CMD: begin
                        if (rx_byte[7]) begin
                            phase <= qspi_csr_pkg::PH_DATA; // writes have no turnaround
                        end else begin
                            phase <= qspi_csr_pkg::PH_TURN;
                        end
                    end
                    qspi_csr_pkg::PH_TURN: phase <= qspi_csr_pkg::PH_DATA;
                    default:               phase <= qspi_csr_pkg::PH_DATA;
                endcase
            end
        end
    end

    // cmd and wr_byte outlive the frame so the clk side can still read them
    always_ff @(posedge sck) begin
        hi_nib <= sdi;
        if (byte_end && (phase == qspi_csr_pkg::PH_CMD)) begin
            cmd.is_write <= rx_byte[7];
            cmd.addr     <= rx_byte[4:0];
        end
        if (wr_evt) begin
            wr_byte <= rx_byte;
        end
    end

    // toggles cross frames, only the global reset clears them
    always_ff @(posedge sck or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            wr_toggle <= 1'b0;
            rd_toggle <= 1'b0;
        end else begin
            if (wr_evt) begin
                wr_toggle <= ~wr_toggle;
            end
            if (rd_evt) begin
                rd_toggle <= ~rd_toggle;
            end
        end
    end

    always_ff @(negedge sck or negedge frame_rst_n) begin
        if (!frame_rst_n) begin
            tx_reg <= 8'h00;
            sdo_en <= 1'b0;
        end else if (tx_load) begin
            tx_reg <= rd_data; // prefetched entry, settled long ago
            sdo_en <= 1'b1;    // stays on to the end of the frame
        end else begin
            tx_reg <= {tx_reg[3:0], 4'h0};
        end
    end

endmodule

// ==== design/qspi_apb_master.sv ====
// one APB transfer per port event; events closer than a transfer plus sync latency are lost
`timescale 1ns/1ps

module qspi_apb_master (
    input  logic                    clk,
    input  logic                    spi_reset_n,
    input  logic                    nss,
    input  qspi_csr_pkg::qspi_cmd_t cmd,
    input  logic [7:0]              wr_byte,
    input  logic                    wr_toggle,
    input  logic                    rd_toggle,
    input  qspi_csr_pkg::apb_rsp_t  rsp,
    output qspi_csr_pkg::apb_req_t  req,
    output logic [7:0]              rd_data
);

    logic [3:0]               wr_sync;   // [2:0] synchronizer, [3] last value
    logic [3:0]               rd_sync;
    logic [2:0]               nss_sync;
    logic                     wr_edge;
    logic                     rd_edge;
    logic                     frame_idle;
    logic                     start;
    logic                     rd_done;
    qspi_csr_pkg::apb_state_e state;
    logic                     is_write_q;
    qspi_csr_pkg::addr_t      addr_q;
    logic [7:0]               wdata_q;
    logic [7:0]               pf_buf [2]; // read prefetch entries
    logic                     pf_wr_ptr;
    logic                     pf_rd_sel;  // tracks the port's load order

    assign wr_edge    = wr_sync[3] ^ wr_sync[2];
    assign rd_edge    = rd_sync[3] ^ rd_sync[2];
    assign frame_idle = nss_sync[2];
    assign start      = (state == qspi_csr_pkg::APB_IDLE) && (wr_edge || rd_edge);
    assign rd_done    = (state == qspi_csr_pkg::APB_ACCESS) && rsp.pready && !is_write_q;

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            wr_sync  <= 4'b0000;
            rd_sync  <= 4'b0000;
            nss_sync <= 3'b111; // bus idle
        end else begin
            wr_sync  <= {wr_sync[2:0], wr_toggle};
            rd_sync  <= {rd_sync[2:0], rd_toggle};
            nss_sync <= {nss_sync[1:0], nss};
        end
    end

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            state      <= qspi_csr_pkg::APB_IDLE;
            is_write_q <= 1'b0;
        end else begin
            case (state)
                qspi_csr_pkg::APB_IDLE: begin
                    if (start) begin
                        state      <= qspi_csr_pkg::APB_SETUP;
                        is_write_q <= wr_edge;
                    end
                end
                qspi_csr_pkg::APB_SETUP: state <= qspi_csr_pkg::APB_ACCESS;
                qspi_csr_pkg::APB_ACCESS: begin
                    if (rsp.pready) begin
                        state <= qspi_csr_pkg::APB_IDLE;
                    end
                end
                default: state <= qspi_csr_pkg::APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= cmd.addr;
            if (wr_edge) begin
                wdata_q <= wr_byte;
            end
        end
        if (rd_done) begin
            pf_buf[pf_wr_ptr] <= rsp.prdata;
        end
    end

    // both pointers restart with each frame, like the port's load order
    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            pf_wr_ptr <= 1'b0;
            pf_rd_sel <= 1'b0;
        end else if (frame_idle) begin
            pf_wr_ptr <= 1'b0;
            pf_rd_sel <= 1'b0;
        end else if (rd_done) begin
            pf_wr_ptr <= ~pf_wr_ptr;
            pf_rd_sel <= pf_wr_ptr; // newest entry goes out next
        end
    end

    assign rd_data = pf_buf[pf_rd_sel];

    always_comb begin
        req.psel    = (state != qspi_csr_pkg::APB_IDLE);
        req.penable = (state == qspi_csr_pkg::APB_ACCESS);
        req.pwrite  = is_write_q;
        req.paddr   = addr_q;
        req.pwdata  = wdata_q;
    end

endmodule

// ==== design/csr_reg_bank.sv ====
// zero-wait slave; only paddr[3:0] is decoded, the mux keeps other addresses away
`timescale 1ns/1ps

module csr_reg_bank (
    input  logic                   clk,
    input  logic                   spi_reset_n,
    input  qspi_csr_pkg::apb_req_t req,
    output qspi_csr_pkg::apb_rsp_t rsp
);

    logic [7:0] regs [16];
    logic       wr_en;
    logic [3:0] idx;

    assign idx   = req.paddr[3:0];
    assign wr_en = req.psel && req.penable && req.pwrite; // access phase only

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (wr_en) begin
            regs[idx] <= req.pwdata;
        end
    end

    always_comb begin
        rsp.prdata = regs[idx];
        rsp.pready = 1'b1; // no wait states
    end

endmodule

// ==== design/mailbox_fifo.sv ====
// MBOX_DEPTH must be a power of two up to 128 so the count fits in one byte
`timescale 1ns/1ps

module mailbox_fifo #(
    parameter int MBOX_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   spi_reset_n,
    input  qspi_csr_pkg::apb_req_t req,
    output qspi_csr_pkg::apb_rsp_t rsp,
    output logic                   not_empty
);

    localparam int PTR_W = $clog2(MBOX_DEPTH);

    logic [7:0]       mem [MBOX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             access;
    logic             data_sel;
    logic             full;
    logic             push;
    logic             pop;

    assign access   = req.psel && req.penable;
    assign data_sel = (req.paddr == qspi_csr_pkg::MBOX_DATA_ADDR);
    assign full     = (count == (PTR_W + 1)'(MBOX_DEPTH));
    assign push     = access && data_sel && req.pwrite && !full;    // full drops it
    assign pop      = access && data_sel && !req.pwrite && not_empty;
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req.pwdata;
        end
    end

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at the power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        rsp.pready = 1'b1;
        if (req.paddr == qspi_csr_pkg::MBOX_COUNT_ADDR) begin
            rsp.prdata = 8'(count);
        end else if (data_sel && not_empty) begin
            rsp.prdata = mem[rd_ptr]; // head of queue
        end else begin
            rsp.prdata = 8'h00;
        end
    end

endmodule

// ==== design/apb_slave_mux.sv ====
// pure decode; unmapped addresses answer locally and never reach a peripheral
`timescale 1ns/1ps

module apb_slave_mux (
    input  qspi_csr_pkg::apb_req_t req,
    input  qspi_csr_pkg::apb_rsp_t regbank_rsp,
    input  qspi_csr_pkg::apb_rsp_t mbox_rsp,
    output qspi_csr_pkg::apb_req_t regbank_req,
    output qspi_csr_pkg::apb_req_t mbox_req,
    output qspi_csr_pkg::apb_rsp_t rsp
);

    logic sel_regbank;
    logic sel_mbox;

    assign sel_regbank = (req.paddr <= qspi_csr_pkg::REGBANK_LAST);
    assign sel_mbox    = (req.paddr == qspi_csr_pkg::MBOX_DATA_ADDR) ||
                         (req.paddr == qspi_csr_pkg::MBOX_COUNT_ADDR);

    always_comb begin
        regbank_req      = req;
        regbank_req.psel = req.psel && sel_regbank;
        mbox_req         = req;
        mbox_req.psel    = req.psel && sel_mbox;

        if (sel_regbank) begin
            rsp = regbank_rsp;
        end else if (sel_mbox) begin
            rsp = mbox_rsp;
        end else begin
            rsp.prdata = qspi_csr_pkg::UNMAPPED_READ; // writes just vanish
            rsp.pready = 1'b1;
        end
    end

endmodule

// ==== design/qspi_csr_top.sv ====
// split sdi/sdo/sdo_en pins, tristate outside; sck at most clk/8, no error responses
`timescale 1ns/1ps

module qspi_csr_top #(
    parameter int MBOX_DEPTH = 8
) (
    input  logic       clk,
    input  logic       spi_reset_n,
    input  logic       sck,
    input  logic       nss,
    input  logic [3:0] sdi,
    output logic [3:0] sdo,
    output logic       sdo_en,
    output logic       mailbox_irq
);

    qspi_csr_pkg::qspi_cmd_t cmd;
    logic [7:0]              wr_byte;
    logic                    wr_toggle;
    logic                    rd_toggle;
    logic [7:0]              rd_data;
    qspi_csr_pkg::apb_req_t  apb_req;
    qspi_csr_pkg::apb_rsp_t  apb_rsp;
    qspi_csr_pkg::apb_req_t  regbank_req;
    qspi_csr_pkg::apb_rsp_t  regbank_rsp;
    qspi_csr_pkg::apb_req_t  mbox_req;
    qspi_csr_pkg::apb_rsp_t  mbox_rsp;

    qspi_serial_port u_port (
        .sck         (sck),
        .nss         (nss),
        .spi_reset_n (spi_reset_n),
        .sdi         (sdi),
        .rd_data     (rd_data),
        .sdo         (sdo),
        .sdo_en      (sdo_en),
        .cmd         (cmd),
        .wr_byte     (wr_byte),
        .wr_toggle   (wr_toggle),
        .rd_toggle   (rd_toggle)
    );

    qspi_apb_master u_master (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .nss         (nss),
        .cmd         (cmd),
        .wr_byte     (wr_byte),
        .wr_toggle   (wr_toggle),
        .rd_toggle   (rd_toggle),
        .rsp         (apb_rsp),
        .req         (apb_req),
        .rd_data     (rd_data)
    );

    apb_slave_mux u_mux (
        .req         (apb_req),
        .regbank_rsp (regbank_rsp),
        .mbox_rsp    (mbox_rsp),
        .regbank_req (regbank_req),
        .mbox_req    (mbox_req),
        .rsp         (apb_rsp)
    );

    csr_reg_bank u_regbank (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .req         (regbank_req),
        .rsp         (regbank_rsp)
    );

    mailbox_fifo #(
        .MBOX_DEPTH  (MBOX_DEPTH)
    ) u_mbox (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .req         (mbox_req),
        .rsp         (mbox_rsp),
        .not_empty   (mailbox_irq)
    );

endmodule

// ==== testbench/tb_qspi_csr.sv ====
// sck runs at clk/8 with nss high between frames; mailbox depth fixed at 8 for the expected model
`timescale 1ns/1ps

module tb_qspi_csr;

    localparam int DEPTH    = 8;
    localparam int GAP_CLKS = 12;  // nss high time between frames
    localparam int WAIT_MAX = 200;

    logic       clk;
    logic       spi_reset_n;
    logic       sck;
    logic       nss;
    logic [3:0] sdi;
    logic [3:0] sdo;
    logic       sdo_en;
    logic       mailbox_irq;

    logic [31:0] lcg_state;
    logic [7:0]  wr_bytes [$];   // data bytes of the next write frame
    logic [7:0]  rd_bytes [$];   // data bytes seen in the last read frame
    logic [7:0]  model_regs [16];
    logic [7:0]  model_mbox [$]; // expected mailbox contents, head first

    qspi_csr_top #(
        .MBOX_DEPTH  (DEPTH)
    ) DUT (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .sck         (sck),
        .nss         (nss),
        .sdi         (sdi),
        .sdo         (sdo),
        .sdo_en      (sdo_en),
        .mailbox_irq (mailbox_irq)
    );

    always #4 clk = ~clk;

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s got %02h expected %02h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s got %0b expected %0b", $time, name, got, exp));
        end
    endtask

    task automatic check_addr_data(input qspi_csr_pkg::qspi_cmd_t cmd, input int idx,
                                   input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t data[%0d] of addr %02h got %02h expected %02h",
                                $time, idx, cmd.addr, got, exp));
        end
    endtask

    // expected behavior of the address map
    task automatic model_write(input qspi_csr_pkg::addr_t addr, input logic [7:0] data);
        if (addr <= 5'h0f) begin
            model_regs[addr[3:0]] = data;
        end else if (addr == 5'h10 && model_mbox.size() < DEPTH) begin
            model_mbox.push_back(data); // full mailbox drops it
        end
    endtask

    task automatic model_read(input qspi_csr_pkg::addr_t addr, output logic [7:0] data);
        if (addr <= 5'h0f) begin
            data = model_regs[addr[3:0]];
        end else if (addr == 5'h10) begin
            if (model_mbox.size() > 0) begin
                data = model_mbox.pop_front();
            end else begin
                data = 8'h00; // empty, nothing popped
            end
        end else if (addr == 5'h11) begin
            data = 8'(model_mbox.size());
        end else begin
            data = 8'hee;
        end
    endtask

    // one sck period, sdo sampled just before the rising edge
    task automatic send_nibble(input logic [3:0] nib, output logic [3:0] sampled);
        @(posedge clk);
        sdi <= nib;
        repeat (3) @(posedge clk);
        sampled = sdo;
        sck <= 1'b1;
        repeat (4) @(posedge clk);
        sck <= 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] out, output logic [7:0] in);
        logic [3:0] hi;
        logic [3:0] lo;
        send_nibble(out[7:4], hi);
        send_nibble(out[3:0], lo);
        in = {hi, lo};
    endtask

    task automatic run_frame(input qspi_csr_pkg::qspi_cmd_t cmd, input int n_data);
        logic [7:0] got;
        logic [7:0] out;
        rd_bytes.delete();
        @(posedge clk);
        nss <= 1'b0;
        send_byte({cmd.is_write, 2'b00, cmd.addr}, got);
        if (!cmd.is_write) begin
            send_byte(8'h00, got); // turnaround byte
        end
        for (int i = 0; i < n_data; i++) begin
            out = cmd.is_write ? wr_bytes[i] : 8'h00;
            send_byte(out, got);
            if (cmd.is_write) begin
                check_flag("sdo_en", sdo_en, 1'b0);
            end else begin
                check_flag("sdo_en", sdo_en, 1'b1);
                rd_bytes.push_back(got);
            end
        end
        repeat (2) @(posedge clk);
        nss <= 1'b1;
        repeat (GAP_CLKS) @(posedge clk);
        check_flag("sdo_en", sdo_en, 1'b0); // released with nss high
    endtask

    task automatic load_wr_bytes(input int n);
        wr_bytes.delete();
        for (int i = 0; i < n; i++) begin
            wr_bytes.push_back(next_rand());
        end
    endtask

    task automatic write_frame(input qspi_csr_pkg::addr_t addr);
        qspi_csr_pkg::qspi_cmd_t cmd;
        cmd.is_write = 1'b1;
        cmd.addr     = addr;
        run_frame(cmd, wr_bytes.size());
        foreach (wr_bytes[i]) begin
            model_write(addr, wr_bytes[i]);
        end
    endtask

    // N data bytes cost N+1 reads, the last one is a lost prefetch
    task automatic read_check(input qspi_csr_pkg::addr_t addr, input int n);
        qspi_csr_pkg::qspi_cmd_t cmd;
        logic [7:0]              exp;
        cmd.is_write = 1'b0;
        cmd.addr     = addr;
        run_frame(cmd, n);
        for (int k = 0; k <= n; k++) begin
            model_read(addr, exp);
            if (k < n) begin
                check_addr_data(cmd, k, rd_bytes[k], exp);
            end
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (mailbox_irq !== level && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (mailbox_irq !== level) begin
            abort_run($sformatf("timed out waiting for mailbox_irq to become %0b", level));
        end
    endtask

    task automatic test_reset_state();
        check_flag("sdo_en", sdo_en, 1'b0);
        check_flag("mailbox_irq", mailbox_irq, 1'b0);
        load_wr_bytes(2);
        write_frame(5'h00); // sdo_en watched through the frame
    endtask

    task automatic test_regbank();
        for (int a = 0; a < 16; a++) begin
            load_wr_bytes(1);
            write_frame(5'(a));
        end
        for (int a = 0; a < 16; a++) begin
            read_check(5'(a), 3);
        end
        load_wr_bytes(3);
        write_frame(5'h05);
        read_check(5'h05, 3);
        check_byte("reg_05", rd_bytes[0], wr_bytes[2]); // last byte wins
    endtask

    task automatic test_mailbox_order();
        load_wr_bytes(5);
        write_frame(5'h10);
        wait_irq(1'b1);
        read_check(5'h11, 1);
        check_byte("mbox_count", rd_bytes[0], 8'd5);
        while (model_mbox.size() > 0) begin
            read_check(5'h10, 1);
        end
        wait_irq(1'b0);
    endtask

    task automatic test_prefetch();
        load_wr_bytes(6);
        write_frame(5'h10);
        read_check(5'h10, 3);
        check_byte("mbox_head", rd_bytes[0], wr_bytes[0]);
        read_check(5'h11, 1);
        check_byte("mbox_count", rd_bytes[0], 8'd2); // 4 entries gone
        read_check(5'h10, 1);
        wait_irq(1'b0);
    endtask

    task automatic test_mailbox_limits();
        load_wr_bytes(10);
        write_frame(5'h10);
        read_check(5'h11, 1);
        check_byte("mbox_count", rd_bytes[0], 8'd8);
        read_check(5'h10, 8);
        check_byte("mbox_head", rd_bytes[0], wr_bytes[0]);
        check_byte("mbox_tail", rd_bytes[7], wr_bytes[7]);
        read_check(5'h10, 2);
        check_byte("mbox_empty", rd_bytes[0], 8'h00);
        wait_irq(1'b0);
    endtask

    task automatic test_unmapped();
        for (int a = 5'h12; a <= 5'h1f; a++) begin
            load_wr_bytes(1);
            write_frame(5'(a));
            read_check(5'(a), 2);
        end
    endtask

    initial begin
        clk         = 1'b0;
        spi_reset_n = 1'b0;
        sck         = 1'b0;
        nss         = 1'b1;
        sdi         = 4'h0;
        lcg_state   = 32'h3089_bb52;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = 8'h00;
        end
        repeat (2) @(posedge clk);
        spi_reset_n <= 1'b1;
        repeat (4) @(posedge clk);

        test_reset_state();
        test_regbank();
        test_mailbox_order();
        test_prefetch();
        test_mailbox_limits();
        test_unmapped();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
design/qspi_csr_pkg.sv
design/qspi_serial_port.sv
design/qspi_apb_master.sv
design/csr_reg_bank.sv
design/mailbox_fifo.sv
design/apb_slave_mux.sv
design/qspi_csr_top.sv
testbench/tb_qspi_csr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_qspi_csr \
    --Mdir obj_dir -o sim_tb_qspi_csr
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb_qspi_csr
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0
